/* common/la32Pkg.sv */
`include "la32_cfg.svh"

package la32Pkg;

    typedef logic [31:0]          instWord_t;  // Raw LA32R instruction
    typedef logic [`IMEM_AW-1:0]  imemAddr_t;  // Word index into imem
    typedef logic [31:0]          pc_t;        // Byte address

    // Instruction class, routes to the execution pipe
    typedef enum logic [2:0] {
        typeAlu  = 3'd0,
        typeBr   = 3'd1,
        typeDiv  = 3'd2,
        typePriv = 3'd3,
        typeMul  = 3'd4,
        typeMem  = 3'd5,
        typeLlsc = 3'd6   // LL.W and SC.W
    } instType_t;

    typedef enum logic [3:0] {
        aluAnd   = 4'd0,
        aluOr    = 4'd1,
        aluNor   = 4'd2,
        aluXor   = 4'd3,
        aluAdd   = 4'd4,
        aluSub   = 4'd5,
        aluSll   = 4'd6,
        aluSrl   = 4'd7,
        aluSra   = 4'd8,
        aluSlt   = 4'd9,   // Signed compare
        aluSltu  = 4'd10,  // Unsigned compare
        aluPassA = 4'd11,
        aluPassB = 4'd12
    } aluOp_t;

    // Where the next PC comes from
    typedef enum logic [1:0] {
        pcBranch    = 2'd0,
        pcWriteback = 2'd1,
        pcPredecode = 2'd2,
        pcPredict   = 2'd3
    } pcSrc_t;

    typedef enum logic {
        fsIdle = 1'b0,
        fsRun  = 1'b1
    } fetchState_t;

endpackage

/* common/la32_cfg.svh */
`ifndef LA32_CFG_SVH
`define LA32_CFG_SVH

// Instruction memory geometry
`define IMEM_AW    6
`define IMEM_DEPTH (1 << `IMEM_AW)

// Width of the fetch run-length counter
`define RUN_W      7

`endif

/* decode/instDecoder.sv */
`timescale 1ns/100ps

module instDecoder (
    input  logic                clk,
    input  logic                rstN,
    input  la32Pkg::instWord_t  inst,
    input  logic                instValid,
    input  la32Pkg::pc_t        instPc,
    output logic                decValid,
    output la32Pkg::pc_t        decPc,
    output la32Pkg::instType_t  instType,
    output la32Pkg::aluOp_t     aluOp,
    output la32Pkg::pcSrc_t     pcSrc,
    output logic                memRead,
    output logic                memWrite,
    output logic                regWrite,
    output logic                illegal
);
    import la32Pkg::*;

    logic [5:0] op6;
    logic [3:0] op4;
    logic [6:0] op7;

    instType_t typeNxt;
    aluOp_t    opNxt;
    pcSrc_t    srcNxt;
    logic      rdNxt;
    logic      wrNxt;
    logic      rwNxt;
    logic      privWb;  // Exception-style priv op
    logic      bad;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op7 = inst[21:15];

    always_comb begin
        typeNxt = typeAlu;
        opNxt   = aluAnd;
        srcNxt  = pcBranch;
        rdNxt   = 1'b0;
        wrNxt   = 1'b0;
        rwNxt   = 1'b0;
        privWb  = 1'b0;
        bad     = 1'b0;
        case (op6)
            6'b000000: begin
                rwNxt = 1'b1;  // Nearly every op here writes rd
                case (op4)
                    4'b0000: begin
                        case (op7)
                            7'b0100000: opNxt = aluAdd;
                            7'b0100010: opNxt = aluSub;
                            7'b0100100: opNxt = aluSlt;
                            7'b0100101: opNxt = aluSltu;
                            7'b0101000: opNxt = aluNor;
                            7'b0101001: opNxt = aluAnd;
                            7'b0101010: opNxt = aluOr;
                            7'b0101011: opNxt = aluXor;
                            7'b0101110: opNxt = aluSll;
                            7'b0101111: opNxt = aluSrl;
                            7'b0110000: opNxt = aluSra;
                            7'b0111000, 7'b0111001, 7'b0111010: typeNxt = typeMul;
                            7'b1000000, 7'b1000001,
                            7'b1000010, 7'b1000011: typeNxt = typeDiv;
                            7'b1010100, 7'b1010110: privWb = 1'b1;  // BREAK, SYSCALL
                            default: bad = 1'b1;
                        endcase
                    end
                    4'b0001: begin
                        // SLLI, SRLI, SRAI share one slot
                        if (inst[21:20] == 2'b00 && inst[17:15] == 3'b001) begin
                            case (inst[19:18])
                                2'b00:   opNxt = aluSll;
                                2'b01:   opNxt = aluSrl;
                                2'b10:   opNxt = aluSra;
                                default: bad = 1'b1;
                            endcase
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    4'b1000: opNxt = aluSlt;   // SLTI
                    4'b1001: opNxt = aluSltu;  // SLTUI
                    4'b1010: opNxt = aluAdd;   // ADDI.W
                    4'b1101: opNxt = aluAnd;
                    4'b1110: opNxt = aluOr;
                    4'b1111: opNxt = aluXor;
                    default: bad = 1'b1;
                endcase
            end
            6'b000001: begin
                case (inst[25:24])
                    2'b00: begin
                        typeNxt = typePriv;  // CSRRD, CSRWR, CSRXCHG
                        opNxt   = aluPassA;
                        rwNxt   = 1'b1;
                    end
                    2'b10: begin
                        case (inst[23:22])
                            2'b00: privWb = 1'b1;  // CACOP
                            2'b01: begin
                                if (inst[21:17] == 5'b00100 && inst[9:0] == 10'd0) begin
                                    case (inst[16:15])
                                        2'b00:   privWb = (inst[14:10] == 5'b01110);  // ERTN
                                        2'b01:   privWb = 1'b1;  // IDLE
                                        default: bad = 1'b1;
                                    endcase
                                    // TLB ops share the ERTN slot
                                    bad = bad || (inst[16:15] == 2'b00 && !privWb);
                                end else begin
                                    bad = 1'b1;
                                end
                            end
                            default: bad = 1'b1;
                        endcase
                    end
                    default: bad = 1'b1;
                endcase
            end
            6'b000101, 6'b000111: begin
                opNxt = op6[1] ? aluAdd : aluPassB;  // PCADDU12I or LU12I.W
                rwNxt = 1'b1;
                bad   = inst[25];
            end
            6'b001000: begin
                typeNxt = typeLlsc;
                rwNxt   = 1'b1;
                case (inst[25:24])
                    2'b00:   rdNxt = 1'b1;  // LL.W
                    2'b01:   wrNxt = 1'b1;  // SC.W
                    default: bad = 1'b1;
                endcase
            end
            6'b001010: begin
                typeNxt = typeMem;
                case (op4)
                    4'b0000, 4'b0001, 4'b0010, 4'b1000, 4'b1001: begin
                        rdNxt = 1'b1;
                        rwNxt = 1'b1;
                    end
                    4'b0100, 4'b0101, 4'b0110: wrNxt = 1'b1;
                    4'b1011: ;  // PRELD is only a hint
                    default: bad = 1'b1;
                endcase
            end
            6'b001110: begin
                // IBAR only, DBAR stays out
                if (inst[25:16] == 10'b0001110010 && inst[15]) begin
                    privWb = 1'b1;
                end else begin
                    bad = 1'b1;
                end
            end
            6'b010100: typeNxt = typeBr;  // B
            6'b010110, 6'b010111: begin
                typeNxt = typeBr;
                opNxt   = aluSub;
            end
            6'b011000, 6'b011001: begin
                typeNxt = typeBr;
                opNxt   = aluSlt;
            end
            6'b011010, 6'b011011: begin
                typeNxt = typeBr;
                opNxt   = aluSltu;
            end
            default: bad = 1'b1;
        endcase

        if (privWb) begin
            typeNxt = typePriv;
            srcNxt  = pcWriteback;
            rwNxt   = 1'b0;
        end
        if (bad) begin
            typeNxt = typeAlu;
            opNxt   = aluAnd;
            srcNxt  = pcBranch;
            rdNxt   = 1'b0;
            wrNxt   = 1'b0;
            rwNxt   = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
            decPc    <= '0;
            instType <= typeAlu;
            aluOp    <= aluAnd;
            pcSrc    <= pcBranch;
            memRead  <= 1'b0;
            memWrite <= 1'b0;
            regWrite <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            decValid <= instValid;
            if (instValid) begin
                decPc    <= instPc;
                instType <= typeNxt;
                aluOp    <= opNxt;
                pcSrc    <= srcNxt;
                memRead  <= rdNxt;
                memWrite <= wrNxt;
                regWrite <= rwNxt;
                illegal  <= bad;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        decValid |-> !(memRead && memWrite))
        else $error("decode asks for read and write at once");

    assert property (@(posedge clk) disable iff (!rstN)
        decValid && illegal |-> !regWrite && !memRead && !memWrite)
        else $error("illegal word left side effects enabled");

endmodule

/* hdl/decodeFrontEnd.sv */
`timescale 1ns/100ps
`include "la32_cfg.svh"

module decodeFrontEnd (
    input  logic               clk,
    input  logic               rstN,
    input  logic               hostWe,
    input  la32Pkg::imemAddr_t hostAddr,
    input  la32Pkg::instWord_t hostData,
    input  logic               fetchStart,
    input  la32Pkg::pc_t       startPc,
    input  logic [`RUN_W-1:0]  runLen,
    output logic               fetchBusy,
    output logic               decValid,
    output la32Pkg::pc_t       decPc,
    output la32Pkg::instType_t instType,
    output la32Pkg::aluOp_t    aluOp,
    output la32Pkg::pcSrc_t    pcSrc,
    output logic               memRead,
    output logic               memWrite,
    output logic               regWrite,
    output logic               illegal
);
    import la32Pkg::*;

    logic      fetchReq;
    logic      fetchGrant;
    imemAddr_t fetchAddr;
    logic      memEn;
    logic      memWe;
    imemAddr_t memAddr;
    instWord_t memWdata;
    instWord_t memRdata;
    logic      rdPending;  // imem output is live this cycle
    pc_t       rdPc;

    fetchUnit iFetch (
        .clk        (clk),
        .rstN       (rstN),
        .fetchStart (fetchStart),
        .startPc    (startPc),
        .runLen     (runLen),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchGrant (fetchGrant),
        .fetchBusy  (fetchBusy),
        .rdPending  (rdPending),
        .rdPc       (rdPc)
    );

    imemArbiter iArb (
        .clk        (clk),
        .rstN       (rstN),
        .hostWe     (hostWe),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .fetchReq   (fetchReq),
        .fetchAddr  (fetchAddr),
        .fetchGrant (fetchGrant),
        .memEn      (memEn),
        .memWe      (memWe),
        .memAddr    (memAddr),
        .memWdata   (memWdata)
    );

    instMemory iMem (
        .clk   (clk),
        .en    (memEn),
        .we    (memWe),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

    instDecoder iDec (
        .clk       (clk),
        .rstN      (rstN),
        .inst      (memRdata),
        .instValid (rdPending),
        .instPc    (rdPc),
        .decValid  (decValid),
        .decPc     (decPc),
        .instType  (instType),
        .aluOp     (aluOp),
        .pcSrc     (pcSrc),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .regWrite  (regWrite),
        .illegal   (illegal)
    );

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/100ps
`include "la32_cfg.svh"

module fetchUnit (
    input  logic               clk,
    input  logic               rstN,
    input  logic               fetchStart,
    input  la32Pkg::pc_t       startPc,
    input  logic [`RUN_W-1:0]  runLen,
    output logic               fetchReq,
    output la32Pkg::imemAddr_t fetchAddr,
    input  logic               fetchGrant,
    output logic               fetchBusy,
    output logic               rdPending,
    output la32Pkg::pc_t       rdPc
);
    import la32Pkg::*;

    fetchState_t       state;
    pc_t               pc;
    logic [`RUN_W-1:0] remain;  // Words still to be granted

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= fsIdle;
            remain    <= '0;
            rdPending <= 1'b0;
        end else begin
            rdPending <= fetchGrant;  // Read data lands next cycle
            if (fetchStart) begin
                state  <= (runLen != '0) ? fsRun : fsIdle;
                remain <= runLen;
            end else if (fetchGrant) begin
                remain <= remain - 1'b1;
                if (remain == `RUN_W'(1)) begin
                    state <= fsIdle;  // Last word granted
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchStart) begin
            pc <= startPc;
        end else if (fetchGrant) begin
            pc <= pc + 32'd4;
        end
        if (fetchGrant) begin
            rdPc <= pc;  // Tags the word coming out of imem
        end
    end

    assign fetchReq  = (state == fsRun);
    assign fetchBusy = (state == fsRun);
    assign fetchAddr = pc[`IMEM_AW+1:2];  // Wraps through the memory

    // No grant is taken once the count is spent
    assert property (@(posedge clk) disable iff (!rstN)
        fetchGrant |-> remain != '0)
        else $error("fetch granted with no words left");

    // Busy may only drop after the final grant
    assert property (@(posedge clk) disable iff (!rstN)
        $fell(fetchBusy) |-> $past(fetchGrant) || $past(fetchStart))
        else $error("fetchBusy fell without a grant");

endmodule

/* hdl/imemArbiter.sv */
`timescale 1ns/100ps

module imemArbiter (
    input  logic               clk,
    input  logic               rstN,
    input  logic               hostWe,
    input  la32Pkg::imemAddr_t hostAddr,
    input  la32Pkg::instWord_t hostData,
    input  logic               fetchReq,
    input  la32Pkg::imemAddr_t fetchAddr,
    output logic               fetchGrant,
    output logic               memEn,
    output logic               memWe,
    output la32Pkg::imemAddr_t memAddr,
    output la32Pkg::instWord_t memWdata
);
    import la32Pkg::*;

    // Host always wins and fetch takes the cycles it leaves free
    assign fetchGrant = fetchReq && !hostWe;

    assign memEn    = hostWe || fetchReq;
    assign memWe    = hostWe;
    assign memAddr  = hostWe ? hostAddr : fetchAddr;
    assign memWdata = hostData;  // Only looked at on a write

    // A stalled fetch keeps its request and address until granted
    assert property (@(posedge clk) disable iff (!rstN)
        fetchReq && !fetchGrant |=> fetchReq && $stable(fetchAddr))
        else $error("stalled fetch dropped its request or moved its address");

endmodule

/* hdl/instMemory.sv */
`timescale 1ns/100ps
`include "la32_cfg.svh"

module instMemory (
    input  logic               clk,
    input  logic               en,
    input  logic               we,
    input  la32Pkg::imemAddr_t addr,
    input  la32Pkg::instWord_t wdata,
    output la32Pkg::instWord_t rdata
);
    import la32Pkg::*;

    instWord_t mem [`IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;  // Host load
            end else begin
                rdata <= mem[addr];  // Data valid the cycle after
            end
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# Builds and runs the decode front-end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbDecodeFrontEnd -f vlog.f

./obj_dir/VtbDecodeFrontEnd > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* test/tbDecodeTasks.svh */
`ifndef TB_DECODE_TASKS_SVH
`define TB_DECODE_TASKS_SVH

localparam int NumKinds = 27;
localparam int FirstBad = 23;  // Kinds from here up are illegal encodings

logic [31:0] lfsrState = 32'h7fa2_64f0;

// Galois LFSR for x^32 + x^22 + x^2 + x + 1, one step for every bit taken
function automatic logic [31:0] nextBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsrState[0]};
        lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
    end
    return bits;
endfunction

// One encoding per kind and the decode it must give:
// {base word, mask of random fields, class, ALU op, PC source, rd/wr/rw/illegal}
function automatic logic [76:0] refRule(input int kind);
    case (kind)
        0:  return {32'h00100000, 32'h00007fff, typeAlu, aluAdd, pcBranch, 4'b0010};  // ADD.W
        1:  return {32'h00128000, 32'h00007fff, typeAlu, aluSltu, pcBranch, 4'b0010};  // SLTU
        2:  return {32'h00158000, 32'h00007fff, typeAlu, aluXor, pcBranch, 4'b0010};  // XOR
        3:  return {32'h00488000, 32'h00007fff, typeAlu, aluSra, pcBranch, 4'b0010};  // SRAI.W
        4:  return {32'h02000000, 32'h003fffff, typeAlu, aluSlt, pcBranch, 4'b0010};  // SLTI
        5:  return {32'h03800000, 32'h003fffff, typeAlu, aluOr, pcBranch, 4'b0010};  // ORI
        6:  return {32'h14000000, 32'h01ffffff, typeAlu, aluPassB, pcBranch, 4'b0010};  // LU12I.W
        7:  return {32'h1c000000, 32'h01ffffff, typeAlu, aluAdd, pcBranch, 4'b0010};  // PCADDU12I
        8:  return {32'h001d0000, 32'h00007fff, typeMul, aluAnd, pcBranch, 4'b0010};  // MULH.WU
        9:  return {32'h00218000, 32'h00007fff, typeDiv, aluAnd, pcBranch, 4'b0010};  // MOD.WU
        10: return {32'h28800000, 32'h003fffff, typeMem, aluAnd, pcBranch, 4'b1010};  // LD.W
        11: return {32'h29000000, 32'h003fffff, typeMem, aluAnd, pcBranch, 4'b0100};  // ST.B
        12: return {32'h2ac00000, 32'h003fffff, typeMem, aluAnd, pcBranch, 4'b0000};  // PRELD
        13: return {32'h20000000, 32'h00ffffff, typeLlsc, aluAnd, pcBranch, 4'b1010};  // LL.W
        14: return {32'h21000000, 32'h00ffffff, typeLlsc, aluAnd, pcBranch, 4'b0110};  // SC.W
        15: return {32'h50000000, 32'h03ffffff, typeBr, aluAnd, pcBranch, 4'b0000};  // B
        16: return {32'h5c000000, 32'h03ffffff, typeBr, aluSub, pcBranch, 4'b0000};  // BNE
        17: return {32'h64000000, 32'h03ffffff, typeBr, aluSlt, pcBranch, 4'b0000};  // BGE
        18: return {32'h6c000000, 32'h03ffffff, typeBr, aluSltu, pcBranch, 4'b0000};  // BGEU
        19: return {32'h04000000, 32'h00ffffff, typePriv, aluPassA, pcBranch, 4'b0010};  // CSRRD
        // SYSCALL, ERTN and IBAR leave through the writeback path
        20: return {32'h002b0000, 32'h00007fff, typePriv, aluAnd, pcWriteback, 4'b0000};
        21: return {32'h06483800, 32'h00000000, typePriv, aluAnd, pcWriteback, 4'b0000};
        22: return {32'h38728000, 32'h00007fff, typePriv, aluAnd, pcWriteback, 4'b0000};
        // TLBSRCH, DBAR, opcode 010010, SLLI.W with bits 21:20 set
        23: return {32'h06482800, 32'h00000000, typeAlu, aluAnd, pcBranch, 4'b0001};
        24: return {32'h38720000, 32'h00007fff, typeAlu, aluAnd, pcBranch, 4'b0001};
        25: return {32'h48000000, 32'h03ffffff, typeAlu, aluAnd, pcBranch, 4'b0001};
        26: return {32'h00508000, 32'h00007fff, typeAlu, aluAnd, pcBranch, 4'b0001};
        default: return '0;
    endcase
endfunction

task automatic checkPc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp)
        stopOnError($sformatf("[FAIL] t=%0t %s got %h exp %h", $time, name, got, exp));
endtask

task automatic checkType(input string name, input instType_t got, input instType_t exp);
    if (got !== exp)
        stopOnError($sformatf("[FAIL] t=%0t %s got %s exp %s", $time, name, got.name(), exp.name()));
endtask

task automatic checkOp(input string name, input aluOp_t got, input aluOp_t exp);
    if (got !== exp)
        stopOnError($sformatf("[FAIL] t=%0t %s got %s exp %s", $time, name, got.name(), exp.name()));
endtask

task automatic checkSrc(input string name, input pcSrc_t got, input pcSrc_t exp);
    if (got !== exp)
        stopOnError($sformatf("[FAIL] t=%0t %s got %s exp %s", $time, name, got.name(), exp.name()));
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
        stopOnError($sformatf("[FAIL] t=%0t %s got %b exp %b", $time, name, got, exp));
endtask

// Drives one host write of a kind with random fields and records it in the model
task automatic writeWord(input imemAddr_t addr, input int kind);
    logic [76:0] rule;
    rule = refRule(kind);
    modelKind[addr] = kind;
    hostWe   = 1'b1;
    hostAddr = addr;
    hostData = rule[76:45] | (nextBits(32) & rule[44:13]);
endtask

task automatic checkResult(input pc_t expPc);
    logic [76:0] rule;
    rule = refRule(modelKind[expPc[`IMEM_AW+1:2]]);
    checkPc("decPc", decPc, expPc);
    checkType("instType", instType, instType_t'(rule[12:10]));
    checkOp("aluOp", aluOp, aluOp_t'(rule[9:6]));
    checkSrc("pcSrc", pcSrc, pcSrc_t'(rule[5:4]));
    checkBit("memRead", memRead, rule[3]);
    checkBit("memWrite", memWrite, rule[2]);
    checkBit("regWrite", regWrite, rule[1]);
    checkBit("illegal", illegal, rule[0]);
endtask

`endif

/* test/tbDecodeFrontEnd.sv */
`timescale 1ns/100ps
`include "la32_cfg.svh"

module tbDecodeFrontEnd;
    import la32Pkg::*;

    // Tests need about 400 cycles end to end
    localparam int MaxCycles = 2000;

    logic              clk;
    logic              rstN;
    logic              hostWe;
    imemAddr_t         hostAddr;
    instWord_t         hostData;
    logic              fetchStart;
    pc_t               startPc;
    logic [`RUN_W-1:0] runLen;
    logic              fetchBusy;
    logic              decValid;
    pc_t               decPc;
    instType_t         instType;
    aluOp_t            aluOp;
    pcSrc_t            pcSrc;
    logic              memRead;
    logic              memWrite;
    logic              regWrite;
    logic              illegal;

    int cycles = 0;
    int modelKind [`IMEM_DEPTH];  // Kind of the word at each address

    decodeFrontEnd i_dut (.*);

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tbDecodeTasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            stopOnError($sformatf("timeout, the run did not end within %0d cycles", MaxCycles));
        end
    end

    // Runs len words from start and checks each result, the timing and the quiet tail.
    // Host writes go to hostBase upward from cycle hostAt, which is 2 or later
    task automatic runCheck(input pc_t start, input int len, input int hostAt,
                            input int hostCnt, input imemAddr_t hostBase);
        pc_t expPc;
        int  seen;
        int  first;
        int  last;
        int  h;
        @(negedge clk);
        fetchStart = 1'b1;
        startPc    = start;
        runLen     = `RUN_W'(len);
        expPc = start;
        seen  = 0;
        first = 0;
        last  = 0;
        h     = 0;
        for (int cyc = 1; seen < len || cyc <= last + 4; cyc++) begin
            @(negedge clk);
            fetchStart = 1'b0;
            hostWe     = 1'b0;
            if (cyc == 1) begin
                checkBit("fetchBusy", fetchBusy, 1'b1);
            end
            if (decValid) begin
                if (seen == len) begin
                    stopOnError($sformatf("extra decValid at cycle %0d of a %0d-word run", cyc, len));
                end
                if (seen == 0) begin
                    first = cyc;
                end
                checkResult(expPc);
                seen++;
                last  = cyc;
                expPc = expPc + 32'd4;
                if (seen == len) begin
                    checkBit("fetchBusy", fetchBusy, 1'b0);  // Dropped after the last grant
                end
            end
            if (h < hostCnt && cyc >= hostAt) begin
                writeWord(imemAddr_t'(hostBase + h), FirstBad + h % 4);
                h++;
            end
        end
        if (first != 3 || last != len + 2 + hostCnt) begin
            stopOnError($sformatf("run of %0d words gave results in cycles %0d to %0d, not 3 to %0d",
                                  len, first, last, len + 2 + hostCnt));
        end
    endtask

    task automatic checkResetState();
        checkBit("decValid", decValid, 1'b0);
        checkBit("fetchBusy", fetchBusy, 1'b0);
        checkBit("illegal", illegal, 1'b0);
        checkPc("decPc", decPc, '0);
        checkType("instType", instType, typeAlu);
    endtask

    // Kind table first, then random kinds mixed with the address
    task automatic loadMemory();
        int kind;
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            @(negedge clk);
            kind = (a < NumKinds) ? a : int'((nextBits(5) ^ a) % NumKinds);
            writeWord(imemAddr_t'(a), kind);
        end
        @(negedge clk);
        hostWe = 1'b0;
    endtask

    task automatic decodeLegalWords();
        runCheck(32'd0, FirstBad, 0, 0, '0);
    endtask

    task automatic decodeIllegalWords();
        runCheck(32'(FirstBad * 4), NumKinds - FirstBad, 0, 0, '0);
    endtask

    // Back-to-back results need two reads in flight
    task automatic pipelineTiming();
        runCheck(32'd160, 12, 0, 0, '0);
    endtask

    // Words 14 to 16 are overwritten with illegal kinds before they are fetched
    task automatic hostBackPressure();
        runCheck(32'd0, 20, 5, 3, 6'd14);
    endtask

    task automatic shortAndLongRuns();
        runCheck(32'd252, 1, 0, 0, '0);
        runCheck(32'd120, (1 << `RUN_W) - 1, 0, 0, '0);  // Wraps through memory
    endtask

    initial begin
        rstN       = 1'b0;
        hostWe     = 1'b0;
        hostAddr   = '0;
        hostData   = '0;
        fetchStart = 1'b0;
        startPc    = '0;
        runLen     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkResetState();
        loadMemory();
        decodeLegalWords();
        decodeIllegalWords();
        pipelineTiming();
        hostBackPressure();
        shortAndLongRuns();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+common
+incdir+test
common/la32Pkg.sv
hdl/instMemory.sv
hdl/imemArbiter.sv
hdl/fetchUnit.sv
decode/instDecoder.sv
hdl/decodeFrontEnd.sv
test/tbDecodeFrontEnd.sv
